/* source/aesPkg.sv */
// --------------------
// AES-128 shared types, constants and
// GF(2^8) arithmetic helpers
// --------------------
`default_nettype none

package aesPkg;

  // Block types
  // --------------------
  // One 128-bit word, byte 0 / word 0 in the MSBs (FIPS-197 order)
  typedef union packed {
    logic [0:15][7:0] bytes;   // SubBytes, ShiftRows
    logic [0:3][31:0] words;   // MixColumns, key schedule
  } aesBlock;

  typedef struct packed {
    logic [127:0] key;
    aesBlock      plaintext;
  } cipherRequest;

  typedef struct packed {
    aesBlock ciphertext;
  } cipherResult;

  localparam int numRounds = 10;            // AES-128
  localparam logic [7:0] rconFirst = 8'h01; // Rcon for round 1

  // GF(2^8) helpers
  // --------------------
  // Multiply by x, reduce by x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] xtime(logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Shift-and-add field multiply
  function automatic logic [7:0] gfMul(logic [7:0] a, logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] cur;
    acc = 8'h00;
    cur = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i])
        acc = acc ^ cur; // Add partial product
      cur = xtime(cur);  // Next power of x
    end
    return acc;
  endfunction

endpackage

`default_nettype wire

/* source/aesSbox.sv */
// --------------------
// AES S-box for one byte, computed as
// field inverse plus affine transform
// --------------------
`timescale 1ns/1ns
`default_nettype none

module aesSbox (
  input  logic [7:0] inByte,
  output logic [7:0] outByte
);

  // Inversion chain
  // --------------------
  // x^254 == x^-1 for x != 0, and 0 stays 0
  logic [7:0] pow2, pow3;     // x^2, x^3
  logic [7:0] pow6, pow7;     // x^6, x^7
  logic [7:0] pow14, pow15;
  logic [7:0] pow30, pow31;
  logic [7:0] pow62, pow63;
  logic [7:0] pow126, pow127;
  logic [7:0] inverse;        // x^254

  assign pow2   = aesPkg::gfMul(inByte, inByte);
  assign pow3   = aesPkg::gfMul(pow2, inByte);
  assign pow6   = aesPkg::gfMul(pow3, pow3);     // Square
  assign pow7   = aesPkg::gfMul(pow6, inByte);
  assign pow14  = aesPkg::gfMul(pow7, pow7);
  assign pow15  = aesPkg::gfMul(pow14, inByte);
  assign pow30  = aesPkg::gfMul(pow15, pow15);
  assign pow31  = aesPkg::gfMul(pow30, inByte);
  assign pow62  = aesPkg::gfMul(pow31, pow31);
  assign pow63  = aesPkg::gfMul(pow62, inByte);
  assign pow126 = aesPkg::gfMul(pow63, pow63);
  assign pow127 = aesPkg::gfMul(pow126, inByte);
  assign inverse = aesPkg::gfMul(pow127, pow127); // Final square, no multiply

  // Affine transform
  // --------------------
  // b'_i = b_i ^ b_(i+4) ^ b_(i+5) ^ b_(i+6) ^ b_(i+7) ^ c_i
  // Same thing written as XOR of left rotations
  logic [7:0] rot1, rot2, rot3, rot4;

  assign rot1 = {inverse[6:0], inverse[7]};
  assign rot2 = {inverse[5:0], inverse[7:6]};
  assign rot3 = {inverse[4:0], inverse[7:5]};
  assign rot4 = {inverse[3:0], inverse[7:4]};

  assign outByte = inverse ^ rot1 ^ rot2 ^ rot3 ^ rot4 ^ 8'h63;

endmodule

`default_nettype wire

/* source/aesKeyExpand.sv */
// --------------------
// AES-128 key schedule, one round key per cycle
// --------------------
`timescale 1ns/1ns
`default_nettype none

module aesKeyExpand (
  input  logic           clk,
  input  logic           reset,
  input  logic           load,     // Start a new schedule from key
  input  logic           advance,  // Step to the following round key
  input  logic [127:0]   key,
  output aesPkg::aesBlock roundKey
);

  aesPkg::aesBlock keyReg;   // Current round key
  logic [7:0]      rconReg;  // Rcon for the next step

  aesPkg::aesBlock srcKey;   // Step input
  logic [7:0]      srcRcon;
  logic [0:3][7:0] rotBytes; // RotWord(w3)
  logic [0:3][7:0] subBytes; // SubWord(RotWord(w3))
  logic [31:0]     temp;
  aesPkg::aesBlock nextKey;

  // On load the first step works straight from the key input
  assign srcKey  = load ? key : keyReg;
  assign srcRcon = load ? aesPkg::rconFirst : rconReg;

  assign rotBytes = {srcKey.words[3][23:0], srcKey.words[3][31:24]}; // Rotate left by a byte

  // SubWord
  // --------------------
  for (genvar i = 0; i < 4; i++) begin : gSubWord
    aesSbox sbox (
      .inByte (rotBytes[i]),
      .outByte(subBytes[i])
    );
  end

  assign temp = subBytes ^ {srcRcon, 24'h000000};

  // Chained XOR across the four words
  always_comb begin
    nextKey.words[0] = srcKey.words[0] ^ temp;
    nextKey.words[1] = srcKey.words[1] ^ nextKey.words[0];
    nextKey.words[2] = srcKey.words[2] ^ nextKey.words[1];
    nextKey.words[3] = srcKey.words[3] ^ nextKey.words[2];
  end

  // Key register, no reset
  always_ff @(posedge clk) begin
    if (load || advance)
      keyReg <= nextKey;
  end

  always_ff @(posedge clk) begin
    if (reset)
      rconReg <= aesPkg::rconFirst;
    else if (load || advance)
      rconReg <= aesPkg::xtime(srcRcon); // Rcon doubles every step
  end

  assign roundKey = keyReg;

endmodule

`default_nettype wire

/* source/aesRound.sv */
// --------------------
// One AES encryption round, combinational
// --------------------
`timescale 1ns/1ns
`default_nettype none

module aesRound (
  input  aesPkg::aesBlock state,
  input  aesPkg::aesBlock roundKey,
  input  logic            lastRound, // Skip MixColumns
  output aesPkg::aesBlock nextState
);

  logic [0:15][7:0] sboxOut;
  aesPkg::aesBlock  subState;
  aesPkg::aesBlock  shiftState;
  aesPkg::aesBlock  mixState;

  // MixColumns on one column, a0 in the MSBs
  function automatic logic [31:0] mixColumn(logic [31:0] col);
    logic [7:0] a0, a1, a2, a3;
    logic [7:0] d0, d1, d2, d3; // Doubled bytes
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    d0 = aesPkg::xtime(a0);
    d1 = aesPkg::xtime(a1);
    d2 = aesPkg::xtime(a2);
    d3 = aesPkg::xtime(a3);
    // 3*a is xtime(a) ^ a
    return {d0 ^ d1 ^ a1 ^ a2 ^ a3,
            a0 ^ d1 ^ d2 ^ a2 ^ a3,
            a0 ^ a1 ^ d2 ^ d3 ^ a3,
            d0 ^ a0 ^ a1 ^ a2 ^ d3};
  endfunction

  // SubBytes
  // --------------------
  for (genvar i = 0; i < 16; i++) begin : gSubBytes
    aesSbox sbox (
      .inByte (state.bytes[i]),
      .outByte(sboxOut[i])
    );
  end

  assign subState.bytes = sboxOut;

  // ShiftRows
  // --------------------
  // Byte index is 4*column + row, row r rotates left by r
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shiftState.bytes[4*c + r] = subState.bytes[4*((c + r) % 4) + r];
      end
    end
  end

  // MixColumns
  // --------------------
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      mixState.words[c] = mixColumn(shiftState.words[c]);
    end
  end

  // AddRoundKey
  // --------------------
  assign nextState = (lastRound ? shiftState : mixState) ^ roundKey;

endmodule

`default_nettype wire

/* source/aesCipher128.sv */
// --------------------
// Iterative AES-128 encryption core,
// one round per clock, key expanded on the fly
// --------------------
`timescale 1ns/1ns
`default_nettype none

module aesCipher128 (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,   // One-cycle strobe, ignored when busy
  input  aesPkg::cipherRequest request,
  output logic                 busy,
  output logic                 done,    // One-cycle strobe
  output aesPkg::cipherResult  result   // Held until the next done
);

  aesPkg::aesBlock stateReg;  // Round state
  aesPkg::aesBlock nextState;
  aesPkg::aesBlock roundKey;
  logic [3:0]      roundCnt;  // Round applied at the next edge
  logic            accept;
  logic            lastRound;

  assign accept    = start && !busy;
  assign lastRound = (roundCnt == 4'(aesPkg::numRounds));

  // Key schedule
  // --------------------
  aesKeyExpand keyExpand_i (
    .clk     (clk),
    .reset   (reset),
    .load    (accept),
    .advance (busy),
    .key     (request.key),
    .roundKey(roundKey)
  );

  // Round logic
  // --------------------
  aesRound round_i (
    .state    (stateReg),
    .roundKey (roundKey),
    .lastRound(lastRound),
    .nextState(nextState)
  );

  // State register
  // --------------------
  always_ff @(posedge clk) begin
    if (accept)
      stateReg <= request.plaintext ^ request.key; // Initial AddRoundKey
    else if (busy)
      stateReg <= nextState;
  end

  // Control
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      roundCnt <= 4'd0;
      result   <= '0;
    end else begin
      done <= 1'b0; // Strobe by default
      if (accept) begin
        busy     <= 1'b1;
        roundCnt <= 4'd1; // Round 1 next
      end else if (busy) begin
        if (lastRound) begin
          busy              <= 1'b0;
          done              <= 1'b1;
          roundCnt          <= 4'd0;
          result.ciphertext <= nextState; // Final round output
        end else begin
          roundCnt <= roundCnt + 4'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verif/aesChecker.sv */
// --------------------
// AES-128 result and latency monitor
// with a software reference model
// --------------------
`timescale 1ns/1ns
`default_nettype none

module aesChecker (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 busy,
  input  logic                 done,
  input  aesPkg::cipherRequest request,
  input  aesPkg::cipherResult  result,
  output int                   resultErrors,
  output int                   timingErrors,
  output int                   resultsChecked
);

  logic [7:0]   sboxTable [0:255];
  logic [31:0]  w [0:43];   // Expanded key words
  logic [7:0]   st [0:15];  // State, index 4*column + row
  logic [127:0] expected;
  logic [127:0] got;
  logic         pending;    // Operation in flight
  int           cyc;        // Negedges since accept was seen

  // Reference model
  // --------------------
  // b_i ^ b_(i+4) ^ b_(i+5) ^ b_(i+6) ^ b_(i+7) ^ c_i
  function automatic logic [7:0] affine(logic [7:0] b);
    logic [7:0] c;
    logic [7:0] o;
    c = 8'h63;
    for (int i = 0; i < 8; i++) begin
      o[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8] ^ b[(i + 7) % 8] ^ c[i];
    end
    return o;
  endfunction

  // Inverse by exhaustive search, 0 maps to 0
  task automatic buildSbox();
    logic [7:0] inv;
    for (int x = 0; x < 256; x++) begin
      inv = 8'h00;
      for (int y = 1; y < 256; y++) begin
        if (aesPkg::gfMul(8'(x), 8'(y)) == 8'h01)
          inv = 8'(y);
      end
      sboxTable[x] = affine(inv);
    end
  endtask

  function automatic logic [31:0] subWord(logic [31:0] x);
    return {sboxTable[x[31:24]], sboxTable[x[23:16]], sboxTable[x[15:8]], sboxTable[x[7:0]]};
  endfunction

  task automatic expandKey(input logic [127:0] key);
    logic [31:0] t;
    logic [7:0]  rcon;
    for (int i = 0; i < 4; i++)
      w[i] = key[127 - 32*i -: 32];
    rcon = aesPkg::rconFirst;
    for (int i = 4; i < 44; i++) begin
      t = w[i - 1];
      if (i % 4 == 0) begin
        t    = subWord({t[23:0], t[31:24]}) ^ {rcon, 24'h000000}; // RotWord first
        rcon = aesPkg::xtime(rcon);
      end
      w[i] = w[i - 4] ^ t;
    end
  endtask

  task automatic addRoundKey(input int rnd);
    for (int c = 0; c < 4; c++)
      for (int r = 0; r < 4; r++)
        st[4*c + r] ^= w[4*rnd + c][31 - 8*r -: 8];
  endtask

  // SubBytes then ShiftRows, row r rotated left by r
  task automatic subShift();
    logic [7:0] tmp [0:15];
    for (int c = 0; c < 4; c++)
      for (int r = 0; r < 4; r++)
        tmp[4*c + r] = sboxTable[st[4*((c + r) % 4) + r]];
    for (int i = 0; i < 16; i++)
      st[i] = tmp[i];
  endtask

  task automatic mixColumns();
    logic [7:0] a0, a1, a2, a3;
    for (int c = 0; c < 4; c++) begin
      a0 = st[4*c];
      a1 = st[4*c + 1];
      a2 = st[4*c + 2];
      a3 = st[4*c + 3];
      st[4*c]     = aesPkg::gfMul(8'h02, a0) ^ aesPkg::gfMul(8'h03, a1) ^ a2 ^ a3;
      st[4*c + 1] = a0 ^ aesPkg::gfMul(8'h02, a1) ^ aesPkg::gfMul(8'h03, a2) ^ a3;
      st[4*c + 2] = a0 ^ a1 ^ aesPkg::gfMul(8'h02, a2) ^ aesPkg::gfMul(8'h03, a3);
      st[4*c + 3] = aesPkg::gfMul(8'h03, a0) ^ a1 ^ a2 ^ aesPkg::gfMul(8'h02, a3);
    end
  endtask

  task automatic encrypt(input logic [127:0] key, input logic [127:0] pt,
                         output logic [127:0] ct);
    expandKey(key);
    for (int i = 0; i < 16; i++)
      st[i] = pt[127 - 8*i -: 8];
    addRoundKey(0);
    for (int rnd = 1; rnd <= aesPkg::numRounds; rnd++) begin
      subShift();
      if (rnd < aesPkg::numRounds)
        mixColumns(); // Not in the final round
      addRoundKey(rnd);
    end
    for (int i = 0; i < 16; i++)
      ct[127 - 8*i -: 8] = st[i];
  endtask

  task automatic checkLevel(input string name, input logic value, input logic want);
    if (value !== want) begin
      timingErrors++;
      $display("Error: %s = %h, expected %h at %0t", name, value, want, $time);
    end
  endtask

  // Monitor
  // --------------------
  initial begin
    resultErrors   = 0;
    timingErrors   = 0;
    resultsChecked = 0;
    pending        = 1'b0;
    cyc            = 0;
    buildSbox();
  end

  // Negedge sampling, DUT outputs and stimulus both settled
  always @(negedge clk) begin
    if (reset !== 1'b0) begin
      pending = 1'b0; // Aborted request gets no result
      cyc     = 0;
    end else begin
      if (pending) begin
        cyc++;
        if (cyc <= aesPkg::numRounds) begin
          checkLevel("busy", busy, 1'b1);
          checkLevel("done", done, 1'b0);
        end else begin
          checkLevel("busy", busy, 1'b0);
          checkLevel("done", done, 1'b1);
          if (done) begin
            resultsChecked++;
            got = result.ciphertext;
            if (got !== expected) begin
              resultErrors++;
              $display("Error: result = %h, expected %h", got, expected);
            end
          end
          pending = 1'b0; // Start in this cycle is accepted below
        end
      end else begin
        checkLevel("busy", busy, 1'b0); // Idle core
        checkLevel("done", done, 1'b0); // No extra done
      end
      if (start && !pending) begin
        encrypt(request.key, request.plaintext, expected);
        pending = 1'b1;
        cyc     = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* verif/aesTb.sv */
// --------------------
// AES-128 core testbench, directed and random
// --------------------
`timescale 1ns/1ns
`default_nettype none

module aesTb;

  localparam int numRandom     = 200;
  localparam int numOps        = numRandom + 6;           // Plus directed operations
  localparam int numResults    = numRandom + 5;           // Aborted request gives none
  localparam int timeoutCycles = numOps * 30 + 16 + 100;  // Reset and margin

  logic                 clk;
  logic                 reset;
  logic                 start;
  logic                 busy;
  logic                 done;
  aesPkg::cipherRequest request;
  aesPkg::cipherResult  result;
  int                   resultErrors;
  int                   timingErrors;
  int                   resultsChecked;
  int                   tbErrors;
  int                   seed;

  aesCipher128 dut_i (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .request(request),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  aesChecker check_i (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .busy          (busy),
    .done          (done),
    .request       (request),
    .result        (result),
    .resultErrors  (resultErrors),
    .timingErrors  (timingErrors),
    .resultsChecked(resultsChecked)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [127:0] randomBlock();
    logic [31:0] a, b, c, d;
    a = $random(seed);
    b = $random(seed);
    c = $random(seed);
    d = $random(seed);
    return {a, b, c, d};
  endfunction

  // One-cycle start, returns 1 ns after the accepting edge
  task automatic pulseStart(input logic [127:0] key, input logic [127:0] pt);
    @(posedge clk);
    #1;
    request = {key, pt};
    start   = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic waitDone(input int limit);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < limit) begin
      @(negedge clk);
      n++;
      if (done)
        seen = 1'b1;
    end
    if (!seen) begin
      tbErrors++;
      $display("No done within %0d cycles of the start pulse", limit);
    end
  endtask

  // Watchdog
  initial begin
    #(timeoutCycles * 10);
    $display("Watchdog: run did not finish within %0d cycles", timeoutCycles);
    $display("Verification failed");
    $finish;
  end

  // Stimulus
  // --------------------
  initial begin
    logic [127:0] key;
    logic [127:0] pt;
    seed     = 32'haf20_ca70;
    tbErrors = 0;
    reset    = 1'b1;
    start    = 1'b0;
    request  = '0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // FIPS-197 known answer
    pulseStart(128'h000102030405060708090a0b0c0d0e0f, 128'h00112233445566778899aabbccddeeff);
    waitDone(30);
    if (result.ciphertext !== 128'h69c4e0d86a7b0430d8cdb78070b4c55a) begin
      tbErrors++;
      $display("Error: result = %h, expected %h", result.ciphertext,
               128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    end

    for (int i = 0; i < numRandom; i++) begin
      key = randomBlock();
      pt  = randomBlock();
      pulseStart(key, pt);
      waitDone(30);
    end

    // Start while busy, must be dropped
    pulseStart(randomBlock(), randomBlock());
    repeat (3) @(posedge clk);
    #1;
    request = {randomBlock(), randomBlock()};
    start   = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    waitDone(30);
    repeat (15) @(posedge clk); // Watch for a stray done

    // Back to back, second start lands in the done cycle
    pulseStart(randomBlock(), randomBlock());
    repeat (10) @(posedge clk);
    #1;
    request = {randomBlock(), randomBlock()};
    start   = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    waitDone(30);

    // Reset in the middle of an operation
    pulseStart(randomBlock(), randomBlock());
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (20) @(posedge clk); // Busy and done stay low
    pulseStart(randomBlock(), randomBlock());
    waitDone(30);

    repeat (5) @(posedge clk);
    if (resultsChecked != numResults) begin
      tbErrors++;
      $display("The checker compared %0d results where %0d operations should have finished",
               resultsChecked, numResults);
    end
    $display("Errors: result %0d, timing %0d, testbench %0d (%0d results checked)",
             resultErrors, timingErrors, tbErrors, resultsChecked);
    if (resultErrors + timingErrors + tbErrors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
source/aesPkg.sv
source/aesSbox.sv
source/aesKeyExpand.sv
source/aesRound.sv
source/aesCipher128.sv
verif/aesChecker.sv
verif/aesTb.sv

/* Bender.yml */
package:
  name: aesCipher128

sources:
  - files:
      - source/aesPkg.sv
      - source/aesSbox.sv
      - source/aesKeyExpand.sv
      - source/aesRound.sv
      - source/aesCipher128.sv
  - target: test
    files:
      - verif/aesChecker.sv
      - verif/aesTb.sv
